/* common/soc_addr_pkg.sv */
package soc_addr_pkg;

  // byte address width
  localparam int addr_w = 32;

  // decoded target of a bus address
  typedef enum logic [1:0] {
    region_iram  = 2'd0,
    region_clint = 2'd1,
    region_plic  = 2'd2,
    region_none  = 2'd3
  } region_e;

  // region bases, each region spans 64 KiB
  localparam logic [addr_w-1:0] iram_base   = 32'h0000_0000;
  localparam logic [addr_w-1:0] clint_base  = 32'h0200_0000;
  localparam logic [addr_w-1:0] plic_base   = 32'h0C00_0000;
  localparam logic [addr_w-1:0] region_span = 32'h0001_0000;

  // instruction ram geometry
  localparam int iram_words = 1024;
  localparam int iram_idx_w = 10;

  // clint word indexes, byte offsets 0x0 to 0xc
  localparam logic [1:0] clint_reg_mtime_lo = 2'd0;
  localparam logic [1:0] clint_reg_mtime_hi = 2'd1;
  localparam logic [1:0] clint_reg_cmp_lo   = 2'd2;
  localparam logic [1:0] clint_reg_cmp_hi   = 2'd3;

  // plic word indexes, byte offsets 0x0 and 0x4
  localparam logic plic_reg_pending = 1'b0;
  localparam logic plic_reg_enable  = 1'b1;

endpackage

/* common/soc_bus_pkg.sv */
package soc_bus_pkg;

  localparam int data_w      = 32;
  localparam int strb_w      = data_w / 8;
  localparam int irq_src_num = 32;

  // master side request, taken in any cycle with valid high
  typedef struct packed {
    logic [soc_addr_pkg::addr_w-1:0] addr;
    logic [data_w-1:0]               wdata;
    logic [strb_w-1:0]               wstrb;
    logic                            write;
  } bus_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  // shared slave request, word index instead of byte address
  typedef struct packed {
    logic [soc_addr_pkg::iram_idx_w-1:0] idx;
    logic [data_w-1:0]                   wdata;
    logic [strb_w-1:0]                   wstrb;
    logic                                write;
  } slv_req_t;

endpackage

/* interconnect/soc_xbar.sv */
`timescale 1ns/1ps

module soc_xbar (
  input  logic                           pll_cpu_clk,
  input  logic                           pad_cpu_rst_b,
  input  logic                           i_req_valid,
  input  soc_bus_pkg::bus_req_t          i_req,
  output logic                           o_rsp_valid,
  output soc_bus_pkg::bus_rsp_t          o_rsp,
  output soc_bus_pkg::slv_req_t          o_slv_req,
  output logic                           o_iram_sel,
  output logic                           o_clint_sel,
  output logic                           o_plic_sel,
  input  logic [soc_bus_pkg::data_w-1:0] i_iram_rdata,
  input  logic [soc_bus_pkg::data_w-1:0] i_clint_rdata,
  input  logic [soc_bus_pkg::data_w-1:0] i_plic_rdata
);

  import soc_addr_pkg::*;
  import soc_bus_pkg::*;

  region_e req_region;
  region_e region_q;
  logic    rsp_valid_q;

  // offset compare, wraps below the base so one test covers both bounds
  function automatic region_e decode_region(input logic [addr_w-1:0] addr);
    region_e region;
    region = region_none;
    if ((addr - iram_base) < region_span)
      region = region_iram;
    else if ((addr - clint_base) < region_span)
      region = region_clint;
    else if ((addr - plic_base) < region_span)
      region = region_plic;
    return region;
  endfunction

  assign req_region = decode_region(i_req.addr);

  assign o_iram_sel  = i_req_valid && (req_region == region_iram);
  assign o_clint_sel = i_req_valid && (req_region == region_clint);
  assign o_plic_sel  = i_req_valid && (req_region == region_plic);

  // word index from the bits above the byte lane
  assign o_slv_req.idx   = i_req.addr[iram_idx_w+1:2];
  assign o_slv_req.wdata = i_req.wdata;
  assign o_slv_req.wstrb = i_req.wstrb;
  assign o_slv_req.write = i_req.write;

  always_ff @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      rsp_valid_q <= 1'b0;
      region_q    <= region_none;
    end
    else
    begin
      rsp_valid_q <= i_req_valid;
      if (i_req_valid)
        region_q <= req_region;
    end
  end

  assign o_rsp_valid = rsp_valid_q;

  // slaves registered their data at the accepting edge
  always_comb
  begin
    o_rsp.rdata = '0;
    o_rsp.err   = 1'b0;
    case (region_q)
      region_iram:  o_rsp.rdata = i_iram_rdata;
      region_clint: o_rsp.rdata = i_clint_rdata;
      region_plic:  o_rsp.rdata = i_plic_rdata;
      default:      o_rsp.err   = 1'b1;
    endcase
  end

  a_sel_onehot: assert property (@(posedge pll_cpu_clk) disable iff (!pad_cpu_rst_b)
    $onehot0({o_iram_sel, o_clint_sel, o_plic_sel}))
    else $error("more than one slave selected");

  a_rsp_only_after_req: assert property (@(posedge pll_cpu_clk) disable iff (!pad_cpu_rst_b)
    o_rsp_valid |-> $past(i_req_valid))
    else $error("response without a request one cycle earlier");

endmodule

/* iram/iram.sv */
`timescale 1ns/1ps

module iram (
  input  logic                           pll_cpu_clk,
  input  logic                           i_sel,
  input  soc_bus_pkg::slv_req_t          i_slv_req,
  output logic [soc_bus_pkg::data_w-1:0] o_rdata
);

  import soc_addr_pkg::*;
  import soc_bus_pkg::*;

  logic [data_w-1:0] mem [iram_words];

  // byte lane writes
  always_ff @(posedge pll_cpu_clk)
  begin
    if (i_sel && i_slv_req.write)
    begin
      for (int b = 0; b < strb_w; b++)
      begin
        if (i_slv_req.wstrb[b])
          mem[i_slv_req.idx][b*8 +: 8] <= i_slv_req.wdata[b*8 +: 8];
      end
    end
  end

  // read before write, a write returns the old word
  always_ff @(posedge pll_cpu_clk)
  begin
    if (i_sel)
      o_rdata <= mem[i_slv_req.idx];
  end

  a_idx_in_range: assert property (@(posedge pll_cpu_clk)
    i_sel |-> (int'(i_slv_req.idx) < iram_words))
    else $error("iram index out of range");

endmodule

/* design/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer (
  input  logic                           pll_cpu_clk,
  input  logic                           pad_cpu_rst_b,
  input  logic                           i_sel,
  input  soc_bus_pkg::slv_req_t          i_slv_req,
  output logic [soc_bus_pkg::data_w-1:0] o_rdata,
  output logic                           o_irq_timer
);

  import soc_addr_pkg::*;
  import soc_bus_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        cmp_wr;
  logic [1:0]  reg_idx;

  assign reg_idx = i_slv_req.idx[1:0];
  assign cmp_wr  = i_sel && i_slv_req.write;

  // free running counter, compare written one half at a time
  always_ff @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end
    else
    begin
      mtime_q <= mtime_q + 64'd1;
      if (cmp_wr && (reg_idx == clint_reg_cmp_lo))
        mtimecmp_q[31:0] <= i_slv_req.wdata;
      if (cmp_wr && (reg_idx == clint_reg_cmp_hi))
        mtimecmp_q[63:32] <= i_slv_req.wdata;
    end
  end

  // mtime as held before the accepting edge
  always_ff @(posedge pll_cpu_clk)
  begin
    if (i_sel)
    begin
      case (reg_idx)
        clint_reg_mtime_lo: o_rdata <= mtime_q[31:0];
        clint_reg_mtime_hi: o_rdata <= mtime_q[63:32];
        clint_reg_cmp_lo:   o_rdata <= mtimecmp_q[31:0];
        default:            o_rdata <= mtimecmp_q[63:32];
      endcase
    end
  end

  assign o_irq_timer = (mtime_q >= mtimecmp_q);

  a_mtime_monotonic: assert property (@(posedge pll_cpu_clk) disable iff (!pad_cpu_rst_b)
    mtime_q >= $past(mtime_q))
    else $error("mtime went backwards");

endmodule

/* design/plic_lite.sv */
`timescale 1ns/1ps

module plic_lite (
  input  logic                                pll_cpu_clk,
  input  logic                                pad_cpu_rst_b,
  input  logic                                i_sel,
  input  soc_bus_pkg::slv_req_t               i_slv_req,
  input  logic [soc_bus_pkg::irq_src_num-1:0] i_irq_src,
  output logic [soc_bus_pkg::data_w-1:0]      o_rdata,
  output logic                                o_irq_ext
);

  import soc_addr_pkg::*;
  import soc_bus_pkg::*;

  logic [irq_src_num-1:0] pending_q;
  logic [irq_src_num-1:0] enable_q;

  // source 0 is reserved and never pends
  always_ff @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      pending_q <= '0;
      enable_q  <= '0;
    end
    else
    begin
      pending_q <= {i_irq_src[irq_src_num-1:1], 1'b0};
      if (i_sel && i_slv_req.write && (i_slv_req.idx[0] == plic_reg_enable))
        enable_q <= i_slv_req.wdata;
    end
  end

  // pending is read only
  always_ff @(posedge pll_cpu_clk)
  begin
    if (i_sel)
    begin
      if (i_slv_req.idx[0] == plic_reg_pending)
        o_rdata <= pending_q;
      else
        o_rdata <= enable_q;
    end
  end

  assign o_irq_ext = |(pending_q & enable_q);

endmodule

/* design/soc_top.sv */
`timescale 1ns/1ps

module soc_top (
  input  logic                                pll_cpu_clk,
  input  logic                                pad_cpu_rst_b,
  input  logic                                i_req_valid,
  input  soc_bus_pkg::bus_req_t               i_req,
  input  logic [soc_bus_pkg::irq_src_num-1:0] i_irq_src,
  output logic                                o_rsp_valid,
  output soc_bus_pkg::bus_rsp_t               o_rsp,
  output logic                                o_irq_timer,
  output logic                                o_irq_ext
);

  import soc_bus_pkg::*;

  slv_req_t          slv_req;
  logic              iram_sel;
  logic              clint_sel;
  logic              plic_sel;
  logic [data_w-1:0] iram_rdata;
  logic [data_w-1:0] clint_rdata;
  logic [data_w-1:0] plic_rdata;

  soc_xbar x_soc_xbar (
    .pll_cpu_clk   (pll_cpu_clk  ),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_req_valid   (i_req_valid  ),
    .i_req         (i_req        ),
    .o_rsp_valid   (o_rsp_valid  ),
    .o_rsp         (o_rsp        ),
    .o_slv_req     (slv_req      ),
    .o_iram_sel    (iram_sel     ),
    .o_clint_sel   (clint_sel    ),
    .o_plic_sel    (plic_sel     ),
    .i_iram_rdata  (iram_rdata   ),
    .i_clint_rdata (clint_rdata  ),
    .i_plic_rdata  (plic_rdata   )
  );

  iram x_iram (
    .pll_cpu_clk (pll_cpu_clk),
    .i_sel       (iram_sel   ),
    .i_slv_req   (slv_req    ),
    .o_rdata     (iram_rdata )
  );

  clint_timer x_clint_timer (
    .pll_cpu_clk   (pll_cpu_clk  ),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_sel         (clint_sel    ),
    .i_slv_req     (slv_req      ),
    .o_rdata       (clint_rdata  ),
    .o_irq_timer   (o_irq_timer  )
  );

  plic_lite x_plic_lite (
    .pll_cpu_clk   (pll_cpu_clk  ),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_sel         (plic_sel     ),
    .i_slv_req     (slv_req      ),
    .i_irq_src     (i_irq_src    ),
    .o_rdata       (plic_rdata   ),
    .o_irq_ext     (o_irq_ext    )
  );

endmodule

/* verification/tb_soc_vectors.svh */
`ifndef TB_SOC_VECTORS_SVH
`define TB_SOC_VECTORS_SVH

// one request per entry, response checked one cycle later
typedef struct {
  string       name;
  logic        write;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  strb;
  logic [31:0] src;
  logic [31:0] exp_rdata;
  logic        exp_err;
  logic        chk_rdata;
} vec_t;

localparam int          vec_num    = 28;
localparam int          mtime_gap  = 12;
localparam int          rand_words = 8;
localparam logic [31:0] rand_base  = 32'h0000_0100;
localparam logic [31:0] rand_seed  = 32'h2edb_767d;

// name, write, addr, wdata, strb, src, exp_rdata, exp_err, chk_rdata
vec_t vectors [vec_num] = '{
  '{"iram_full_wr",   1'b1, iram_base + 32'h40, 32'hA5C3_1E77, 4'hF, 32'h0, 32'h0, 1'b0, 1'b0},
  '{"iram_full_rd",   1'b0, iram_base + 32'h40, 32'h0, 4'hF, 32'h0, 32'hA5C3_1E77, 1'b0, 1'b1},
  // write returns the old word
  '{"iram_part_wr",   1'b1, iram_base + 32'h40, 32'h1122_3344, 4'h5, 32'h0, 32'hA5C3_1E77,
    1'b0, 1'b1},
  '{"iram_part_rd",   1'b0, iram_base + 32'h40, 32'h0, 4'hF, 32'h0, 32'hA522_1E44, 1'b0, 1'b1},
  '{"iram_w0",        1'b1, iram_base, 32'h0BAD_F00D, 4'hF, 32'h0, 32'h0, 1'b0, 1'b0},
  '{"hole_rd",        1'b0, 32'h1000_0000, 32'h0, 4'hF, 32'h0, 32'h0, 1'b1, 1'b1},
  '{"hole_rd_lo",     1'b0, 32'h01FF_FFFC, 32'h0, 4'hF, 32'h0, 32'h0, 1'b1, 1'b1},
  // just past the ram, same low index bits as word 0
  '{"hole_wr",        1'b1, iram_base + region_span, 32'hDEAD_BEEF, 4'hF, 32'h0, 32'h0,
    1'b1, 1'b1},
  '{"iram_rd0",       1'b0, iram_base, 32'h0, 4'hF, 32'h0, 32'h0BAD_F00D, 1'b0, 1'b1},
  '{"iram_after_err", 1'b0, iram_base + 32'h40, 32'h0, 4'hF, 32'h0, 32'hA522_1E44, 1'b0, 1'b1},
  '{"mtime_hi_zero",  1'b0, clint_base + 32'h4, 32'h0, 4'hF, 32'h0, 32'h0, 1'b0, 1'b1},
  '{"cmp_lo_reset",   1'b0, clint_base + 32'h8, 32'h0, 4'hF, 32'h0, 32'hFFFF_FFFF, 1'b0, 1'b1},
  '{"cmp_hi_reset",   1'b0, clint_base + 32'hC, 32'h0, 4'hF, 32'h0, 32'hFFFF_FFFF, 1'b0, 1'b1},
  '{"cmp_lo_zero",    1'b1, clint_base + 32'h8, 32'h0, 4'hF, 32'h0, 32'hFFFF_FFFF, 1'b0, 1'b1},
  // zero strobe still writes the compare half
  '{"cmp_hi_zero",    1'b1, clint_base + 32'hC, 32'h0, 4'h0, 32'h0, 32'hFFFF_FFFF, 1'b0, 1'b1},
  '{"cmp_lo_rd",      1'b0, clint_base + 32'h8, 32'h0, 4'hF, 32'h0, 32'h0, 1'b0, 1'b1},
  '{"mtime_hi_wr",    1'b1, clint_base + 32'h4, 32'hFFFF_FFFF, 4'hF, 32'h0, 32'h0, 1'b0, 1'b1},
  '{"mtime_hi_kept",  1'b0, clint_base + 32'h4, 32'h0, 4'hF, 32'h0, 32'h0, 1'b0, 1'b1},
  '{"cmp_hi_big",     1'b1, clint_base + 32'hC, 32'hFFFF_FFFF, 4'hF, 32'h0, 32'h0, 1'b0, 1'b1},
  '{"cmp_lo_big",     1'b1, clint_base + 32'h8, 32'hFFFF_0000, 4'hF, 32'h0, 32'h0, 1'b0, 1'b1},
  '{"cmp_lo_rb",      1'b0, clint_base + 32'h8, 32'h0, 4'hF, 32'h0, 32'hFFFF_0000, 1'b0, 1'b1},
  '{"cmp_hi_rb",      1'b0, clint_base + 32'hC, 32'h0, 4'hF, 32'h0, 32'hFFFF_FFFF, 1'b0, 1'b1},
  '{"plic_en_wr",     1'b1, plic_base + 32'h4, 32'h0000_00F1, 4'hF, 32'h3, 32'h0, 1'b0, 1'b1},
  '{"plic_pend_rd",   1'b0, plic_base, 32'h0, 4'hF, 32'h3, 32'h2, 1'b0, 1'b1},
  '{"plic_en_rd",     1'b0, plic_base + 32'h4, 32'h0, 4'hF, 32'h21, 32'hF1, 1'b0, 1'b1},
  '{"plic_src0_only", 1'b0, plic_base, 32'h0, 4'hF, 32'h1, 32'h0, 1'b0, 1'b1},
  '{"plic_pend_hi",   1'b0, plic_base, 32'h0, 4'hF, 32'h8000_0010, 32'h8000_0010, 1'b0, 1'b1},
  '{"plic_pend_wr",   1'b1, plic_base, 32'hFFFF_FFFF, 4'hF, 32'h4, 32'h4, 1'b0, 1'b1}
};

`endif

/* verification/tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top;

  import soc_addr_pkg::*;
  import soc_bus_pkg::*;

  `include "tb_soc_vectors.svh"

  localparam int rsp_timeout = 16;

  logic                   pll_cpu_clk;
  logic                   pad_cpu_rst_b;
  logic                   req_valid;
  bus_req_t               req;
  logic [irq_src_num-1:0] irq_src;
  logic                   rsp_valid;
  bus_rsp_t               rsp;
  logic                   irq_timer;
  logic                   irq_ext;

  logic        req_valid_d;
  logic [63:0] mtime_model;
  logic [63:0] cmp_model;
  logic [31:0] en_model;
  logic [31:0] rand_state;
  logic [31:0] rand_data [rand_words];
  int          tests_run;
  int          tests_failed;
  int          test_errs;
  int          timing_errs;

  soc_top i_soc_top (
    .pll_cpu_clk   (pll_cpu_clk  ),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_req_valid   (req_valid    ),
    .i_req         (req          ),
    .i_irq_src     (irq_src      ),
    .o_rsp_valid   (rsp_valid    ),
    .o_rsp         (rsp          ),
    .o_irq_timer   (irq_timer    ),
    .o_irq_ext     (irq_ext      )
  );

  initial
  begin
    pll_cpu_clk = 1'b0;
    forever #10 pll_cpu_clk = ~pll_cpu_clk;
  end

  // expected response strobe and expected mtime
  always @(posedge pll_cpu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      req_valid_d <= 1'b0;
      mtime_model <= '0;
    end
    else
    begin
      req_valid_d <= req_valid;
      mtime_model <= mtime_model + 64'd1;
    end
  end

  always @(negedge pll_cpu_clk)
  begin
    if (pad_cpu_rst_b && (rsp_valid !== req_valid_d))
    begin
      $display("FAILED rsp_valid_timing expected %b actual %b", req_valid_d, rsp_valid);
      timing_errs++;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_value(input string name, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s %s expected %h actual %h", name, field, exp, act);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs != 0)
    begin
      tests_failed++;
      $display("FAIL  %s", name);
    end
    else
      $display("ok    %s", name);
    test_errs = 0;
  endtask

  // called at a falling edge
  task automatic drive_req(input logic write, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb);
    req_valid = 1'b1;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    req.wstrb = strb;
  endtask

  task automatic wait_rsp(input string name);
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge pll_cpu_clk);
      cycles++;
    end
    while (!rsp_valid && (cycles < rsp_timeout));
    if (!rsp_valid)
    begin
      $display("no response within %0d cycles for %s", rsp_timeout, name);
      $display("Test failed");
      $finish;
    end
    else if (cycles != 1)
      report_value(name, "latency", 32'd1, 32'(cycles));
  endtask

  initial
  begin
    logic [31:0] t0;
    logic [31:0] t1;
    pad_cpu_rst_b = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    irq_src       = '0;
    tests_run     = 0;
    tests_failed  = 0;
    test_errs     = 0;
    timing_errs   = 0;
    cmp_model     = '1;
    en_model      = '0;
    repeat (10) @(negedge pll_cpu_clk);
    pad_cpu_rst_b = 1'b1;
    @(negedge pll_cpu_clk);
    if (rsp_valid !== 1'b0)
      report_value("after_reset", "rsp_valid", 32'd0, 32'(rsp_valid));
    if (irq_timer !== 1'b0)
      report_value("after_reset", "irq_timer", 32'd0, 32'(irq_timer));
    if (irq_ext !== 1'b0)
      report_value("after_reset", "irq_ext", 32'd0, 32'(irq_ext));
    finish_test("after_reset");

    foreach (vectors[i])
    begin
      // sources lead the request by one edge so pending is settled
      irq_src = vectors[i].src;
      @(negedge pll_cpu_clk);
      drive_req(vectors[i].write, vectors[i].addr, vectors[i].wdata, vectors[i].strb);
      if (vectors[i].write && (vectors[i].addr == clint_base + 32'h8))
        cmp_model[31:0] = vectors[i].wdata;
      if (vectors[i].write && (vectors[i].addr == clint_base + 32'hC))
        cmp_model[63:32] = vectors[i].wdata;
      if (vectors[i].write && (vectors[i].addr == plic_base + 32'h4))
        en_model = vectors[i].wdata;
      wait_rsp(vectors[i].name);
      req_valid = 1'b0;
      if (vectors[i].chk_rdata && (rsp.rdata !== vectors[i].exp_rdata))
        report_value(vectors[i].name, "rdata", vectors[i].exp_rdata, rsp.rdata);
      if (rsp.err !== vectors[i].exp_err)
        report_value(vectors[i].name, "err", 32'(vectors[i].exp_err), 32'(rsp.err));
      if (irq_timer !== (mtime_model >= cmp_model))
        report_value(vectors[i].name, "irq_timer", 32'(mtime_model >= cmp_model),
                     32'(irq_timer));
      if (irq_ext !== (|(irq_src & en_model & 32'hFFFF_FFFE)))
        report_value(vectors[i].name, "irq_ext", 32'(|(irq_src & en_model & 32'hFFFF_FFFE)),
                     32'(irq_ext));
      finish_test(vectors[i].name);
    end

    // two mtime_lo reads accepted mtime_gap edges apart
    drive_req(1'b0, clint_base, 32'h0, 4'hF);
    wait_rsp("mtime_gap");
    t0 = rsp.rdata;
    req_valid = 1'b0;
    repeat (mtime_gap - 1) @(negedge pll_cpu_clk);
    drive_req(1'b0, clint_base, 32'h0, 4'hF);
    wait_rsp("mtime_gap");
    t1 = rsp.rdata;
    req_valid = 1'b0;
    if ((t1 - t0) !== 32'(mtime_gap))
      report_value("mtime_gap", "delta", 32'(mtime_gap), t1 - t0);
    finish_test("mtime_gap");

    // back to back writes then back to back reads
    rand_state = rand_seed;
    for (int k = 0; k < rand_words; k++)
    begin
      rand_state = xorshift32(rand_state);
      rand_data[k] = rand_state;
      drive_req(1'b1, rand_base + 32'(4 * k), rand_state, 4'hF);
      wait_rsp("rand_write");
      if (rsp.err !== 1'b0)
        report_value("rand_write", "err", 32'd0, 32'(rsp.err));
    end
    req_valid = 1'b0;
    finish_test("rand_write");
    for (int k = 0; k < rand_words; k++)
    begin
      drive_req(1'b0, rand_base + 32'(4 * k), 32'h0, 4'hF);
      wait_rsp("rand_read");
      if (rsp.rdata !== rand_data[k])
        report_value("rand_read", "rdata", rand_data[k], rsp.rdata);
    end
    req_valid = 1'b0;
    @(negedge pll_cpu_clk);
    finish_test("rand_read");

    $display("tests run %0d, failed %0d, timing errors %0d", tests_run, tests_failed,
             timing_errs);
    if ((tests_failed == 0) && (timing_errs == 0))
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* list.f */
+incdir+verification
common/soc_addr_pkg.sv
common/soc_bus_pkg.sv
interconnect/soc_xbar.sv
iram/iram.sv
design/clint_timer.sv
design/plic_lite.sv
design/soc_top.sv
verification/tb_soc_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_soc_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
